// File: Bender.yml
package:
  name: iot_filter

export_include_dirs:
  - verilog

sources:
  - verilog/iot_data_pkg.sv
  - verilog/iot_ctrl_pkg.sv
  - verilog/byte_collector.sv
  - verilog/crc3_engine.sv
  - verilog/extreme_tracker.sv
  - verilog/result_sequencer.sv
  - verilog/iot_filter_top.sv
  - target: test
    files:
      - dv/iot_filter_tb.sv

// File: dv/iot_filter_patterns.hex
// header: hold mode, fn code, word count, result count, one byte each
// then the input words, then the expected results, header 0 ends the list
// crc, four words with random gaps
00030404
00000000000000000000000000000001
80000000000000000000000000000000
ffffffffffffffffffffffffffffffff
00000000000000010000000000000020
3
6
5
4
// top2max, equal maxima in words 2 and 4
00040802
11111111222222223333333344444444
7f000000000000000000000000000001
7f000000000000000000000000000005
00ffffffffffffffffffffffffffffff
7f000000000000000000000000000005
7effffffffffffffffffffffffffffff
7f000000000000000000000000000004
0000abcd000000000000000000000000
7f000000000000000000000000000005
7f000000000000000000000000000005
// last2min, smallest first
00050802
a5a5a5a55a5a5a5aa5a5a5a55a5a5a5a
00000000000000000000000000000100
ffffffffffffffffffffffffffffffff
000000000000000000000000000000ff
00000000000000010000000000000000
00000000000000000000000000000080
000000000000000000000000000000ff
01000000000000000000000000000000
80
ff
// crc with in_en held high through busy
01030303
00000000000000000000000000000004
40000000000000000000000000000000
00000000000000000000000000000100
7
3
6
// encrypt code, no output expected
00010100
deadbeef0123456789abcdefcafef00d
0

// File: dv/iot_filter_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "iot_defines.svh"

module iot_filter_tb
    import iot_data_pkg::*;
    import iot_ctrl_pkg::*;
();

    localparam int PAT_DEPTH = 64;

    logic      clk;
    logic      rst;
    logic      in_en;
    iot_byte_t iot_in;
    fn_sel_t   fn_sel;
    logic      busy;
    logic      valid;
    iot_word_t iot_out;

    // pattern image, header then words then expected results
    iot_word_t pat_mem [0:PAT_DEPTH-1];
    // every word seen while valid is high
    iot_word_t got_q [$];

    int ptr;
    int err_cnt;
    int test_cnt;
    int bad_tests;
    int cycle_cnt;
    int cycle_limit;

    iot_filter_top u_iot_filter_top (
        .clk     (clk),
        .rst     (rst),
        .in_en   (in_en),
        .iot_in  (iot_in),
        .fn_sel  (fn_sel),
        .busy    (busy),
        .valid   (valid),
        .iot_out (iot_out)
    );

    // 8 ns period
    always #4 clk = ~clk;

    //////////////////////////////////////////////////////////////////////
    // watchdog and output monitor
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_limit > 0 && cycle_cnt > cycle_limit) begin
            $display("timeout: DUT did not finish within %0d cycles", cycle_limit);
            $display("TESTBENCH FAILED");
            $finish;
        end
    end

    // outputs settle after posedge, so look at the falling edge
    always @(negedge clk) begin
        if (!rst && valid) begin
            got_q.push_back(iot_out);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////////////////////////

    task automatic check_word(string name, iot_word_t got, iot_word_t exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(string name, logic got, logic exp);
        if (got !== exp) begin
            $display("FAIL %s: got %h, expected %h", name, got, exp);
            err_cnt++;
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic apply_reset(fn_sel_t fn);
        @(posedge clk);
        #1;
        rst    = 1'b1;
        in_en  = 1'b0;
        fn_sel = fn;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
    endtask

    // holds the byte until an edge with busy low takes it
    task automatic send_byte(iot_byte_t b);
        logic taken;
        in_en  = 1'b1;
        iot_in = b;
        taken  = 1'b0;
        while (!taken) begin
            @(negedge clk);
            taken = !busy;
            @(posedge clk);
            #1;
        end
    endtask

    // top byte first, optional idle gap of 0..3 cycles before each byte
    task automatic send_word(iot_word_t data, logic hold);
        int gap;
        for (int i = `IOT_WORD_BYTES - 1; i >= 0; i--) begin
            if (!hold) begin
                in_en = 1'b0;
                gap   = $urandom % 4;
                repeat (gap) begin
                    @(posedge clk);
                    #1;
                end
            end
            send_byte(data[i*`IOT_BYTE_W +: `IOT_BYTE_W]);
        end
    endtask

    // last word starts busy one edge later, wait for it to rise and fall
    task automatic wait_idle();
        do @(negedge clk); while (!busy);
        do @(negedge clk); while (busy);
        // short window to catch a stray valid
        repeat (2) @(negedge clk);
    endtask

    //////////////////////////////////////////////////////////////////////
    // test records
    //////////////////////////////////////////////////////////////////////

    // cycle limit from the total byte count of all records
    task automatic set_budget();
        int p;
        int bytes;
        p     = 0;
        bytes = 0;
        while (p < PAT_DEPTH && pat_mem[p][23:16] != 8'd0) begin
            bytes = bytes + pat_mem[p][15:8] * `IOT_WORD_BYTES;
            p     = p + 1 + pat_mem[p][15:8] + pat_mem[p][7:0];
        end
        cycle_limit = bytes * 8 + 200;
    endtask

    task automatic check_reset_state();
        int errs_before;
        errs_before = err_cnt;
        apply_reset(FN_CRC);
        @(negedge clk);
        check_flag("busy", busy, 1'b0);
        check_flag("valid", valid, 1'b0);
        check_word("iot_out", iot_out, '0);
        test_cnt++;
        if (err_cnt != errs_before) begin
            bad_tests++;
        end
        $display("test %0d reset state: %s", test_cnt,
                 (err_cnt == errs_before) ? "ok" : "failed");
    endtask

    // header: [31:24] hold mode, [23:16] fn code, [15:8] words, [7:0] results
    task automatic run_test();
        iot_word_t hdr;
        logic      hold;
        int        n_words;
        int        n_res;
        int        errs_before;
        hdr         = pat_mem[ptr];
        hold        = hdr[24];
        n_words     = hdr[15:8];
        n_res       = hdr[7:0];
        errs_before = err_cnt;
        apply_reset(fn_sel_t'(hdr[18:16]));
        got_q.delete();
        for (int w = 0; w < n_words; w++) begin
            send_word(pat_mem[ptr + 1 + w], hold);
        end
        in_en = 1'b0;
        wait_idle();
        if (got_q.size() != n_res) begin
            $display("result count wrong: %0d valid cycles seen, %0d expected",
                     got_q.size(), n_res);
            err_cnt++;
        end else begin
            for (int r = 0; r < n_res; r++) begin
                check_word("iot_out", got_q[r], pat_mem[ptr + 1 + n_words + r]);
            end
        end
        check_flag("busy", busy, 1'b0);
        check_flag("valid", valid, 1'b0);
        test_cnt++;
        if (err_cnt != errs_before) begin
            bad_tests++;
        end
        $display("test %0d fn %0d, %0d words, %0d results, hold %0d: %s", test_cnt,
                 hdr[23:16], n_words, n_res, hold,
                 (err_cnt == errs_before) ? "ok" : "failed");
        ptr = ptr + 1 + n_words + n_res;
    endtask

    initial begin
        int seed;
        clk         = 1'b0;
        rst         = 1'b1;
        in_en       = 1'b0;
        iot_in      = '0;
        fn_sel      = FN_CRC;
        ptr         = 0;
        err_cnt     = 0;
        test_cnt    = 0;
        bad_tests   = 0;
        cycle_cnt   = 0;
        cycle_limit = 0;
        seed        = $urandom(26645);
        $readmemh("dv/iot_filter_patterns.hex", pat_mem);
        set_budget();
        check_reset_state();
        while (ptr < PAT_DEPTH && pat_mem[ptr][23:16] != 8'd0) begin
            run_test();
        end
        if (test_cnt < 2) begin
            $display("no test records found in the pattern file");
            err_cnt++;
        end
        $display("tests run %0d, tests failed %0d, checks failed %0d",
                 test_cnt, bad_tests, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: files.f
+incdir+verilog
verilog/iot_data_pkg.sv
verilog/iot_ctrl_pkg.sv
verilog/byte_collector.sv
verilog/crc3_engine.sv
verilog/extreme_tracker.sv
verilog/result_sequencer.sv
verilog/iot_filter_top.sv
dv/iot_filter_tb.sv

// File: verilog/byte_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "iot_defines.svh"

module byte_collector
    import iot_data_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_en,
    input  logic      busy,
    input  iot_byte_t iot_in,
    output logic      byte_strobe,
    output logic      first_byte,
    output logic      word_done,
    output iot_byte_t cur_byte,
    output iot_word_t word
);

    // position of the next byte within the word
    byte_idx_t byte_idx;
    logic      accept;

    // busy is the only back-pressure
    assign accept = in_en & ~busy;

    //////////////////////////////////////////////////////////////////////
    // control
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_idx    <= '0;
            byte_strobe <= 1'b0;
            first_byte  <= 1'b0;
            word_done   <= 1'b0;
        end else begin
            byte_strobe <= accept;
            first_byte  <= accept && (byte_idx == '0);
            // index already wrapped to 0 once the 16th byte is in
            word_done   <= byte_strobe && (byte_idx == '0);
            if (accept) begin
                byte_idx <= byte_idx + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // payload
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (accept) begin
            cur_byte <= iot_in;
        end
        // shift in from the bottom, so first byte ends on top
        if (byte_strobe) begin
            word <= {word[`IOT_WORD_W-`IOT_BYTE_W-1:0], cur_byte};
        end
    end

endmodule

`default_nettype wire

// File: verilog/crc3_engine.sv
`timescale 1ns/1ps
`default_nettype none

`include "iot_defines.svh"

module crc3_engine
    import iot_data_pkg::*;
    import iot_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      byte_strobe,
    input  logic      first_byte,
    input  logic      word_done,
    input  iot_byte_t cur_byte,
    input  fn_sel_t   fn_sel,
    output logic      crc_ready,
    output crc_t      crc_value
);

    // running remainder of the current word
    crc_t crc_r;

    // eight lfsr steps, msb first, direct form so no zero tail needed
    function automatic crc_t crc_fold(crc_t seed, iot_byte_t data);
        crc_t c;
        logic fb;
        c = seed;
        for (int i = `IOT_BYTE_W - 1; i >= 0; i--) begin
            fb = c[`IOT_CRC_W-1] ^ data[i];
            c  = {c[`IOT_CRC_W-2:0], 1'b0} ^ (fb ? `IOT_CRC_POLY : crc_t'(0));
        end
        return c;
    endfunction

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            crc_r     <= '0;
            crc_ready <= 1'b0;
        end else begin
            // byte 0 restarts from a zero remainder
            if (byte_strobe) begin
                crc_r <= crc_fold(first_byte ? crc_t'(0) : crc_r, cur_byte);
            end
            crc_ready <= word_done && (fn_sel == FN_CRC);
        end
    end

    // snapshot before a following byte 0 can clobber crc_r
    always_ff @(posedge clk) begin
        if (word_done) begin
            crc_value <= crc_r;
        end
    end

endmodule

`default_nettype wire

// File: verilog/extreme_tracker.sv
`timescale 1ns/1ps
`default_nettype none

`include "iot_defines.svh"

module extreme_tracker
    import iot_data_pkg::*;
    import iot_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      byte_strobe,
    input  logic      first_byte,
    input  logic      word_done,
    input  iot_byte_t cur_byte,
    input  iot_word_t word,
    input  fn_sel_t   fn_sel,
    output logic      round_ready,
    output iot_word_t rank_first,
    output iot_word_t rank_second
);

    // wraps with the collector count, so it is 0 on first_byte
    byte_idx_t byte_idx;
    word_cnt_t word_cnt;
    relation_t rel_first, rel_second;
    relation_t rel_first_nxt, rel_second_nxt;
    relation_t win_rel;
    iot_word_t cand_first_nxt, cand_second_nxt;
    logic      is_top;
    logic      beats_first, beats_second;

    // byte idx counted from the top of the word
    function automatic iot_byte_t pick_byte(iot_word_t w, byte_idx_t idx);
        return w[(`IOT_WORD_BYTES - 1 - idx) * `IOT_BYTE_W +: `IOT_BYTE_W];
    endfunction

    function automatic relation_t byte_rel(iot_byte_t a, iot_byte_t b);
        if (a > b) begin
            return REL_BIGGER;
        end else if (a == b) begin
            return REL_EQUAL;
        end
        return REL_SMALLER;
    endfunction

    // strict wins only, ties keep the earlier word
    assign is_top       = (fn_sel == FN_TOP2MAX);
    assign win_rel      = is_top ? REL_BIGGER : REL_SMALLER;
    assign beats_first  = (rel_first == win_rel);
    assign beats_second = (rel_second == win_rel);

    //////////////////////////////////////////////////////////////////////
    // candidate update and byte compare
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        cand_first_nxt  = rank_first;
        cand_second_nxt = rank_second;
        if (word_done) begin
            if (word_cnt == '0) begin
                // round start, the word is all we know
                cand_first_nxt  = word;
                cand_second_nxt = word;
            end else if (beats_first) begin
                cand_first_nxt  = word;
                cand_second_nxt = rank_first;
            end else if (beats_second || word_cnt == word_cnt_t'(1)) begin
                // 2nd word of a round always displaces the seed copy
                cand_second_nxt = word;
            end
        end
        // compare against the values valid after this edge
        rel_first_nxt  = rel_first;
        rel_second_nxt = rel_second;
        if (first_byte || rel_first == REL_EQUAL) begin
            rel_first_nxt = byte_rel(cur_byte, pick_byte(cand_first_nxt, byte_idx));
        end
        if (first_byte || rel_second == REL_EQUAL) begin
            rel_second_nxt = byte_rel(cur_byte, pick_byte(cand_second_nxt, byte_idx));
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            byte_idx    <= '0;
            word_cnt    <= '0;
            rel_first   <= REL_EQUAL;
            rel_second  <= REL_EQUAL;
            round_ready <= 1'b0;
        end else begin
            if (byte_strobe) begin
                byte_idx   <= byte_idx + 1'b1;
                rel_first  <= rel_first_nxt;
                rel_second <= rel_second_nxt;
            end
            if (word_done) begin
                word_cnt <= word_cnt + 1'b1;
            end
            // last word of the round, ranking functions only
            round_ready <= word_done && (word_cnt == word_cnt_t'(`IOT_ROUND_WORDS - 1))
                           && (is_top || fn_sel == FN_LAST2MIN);
        end
    end

    always_ff @(posedge clk) begin
        rank_first  <= cand_first_nxt;
        rank_second <= cand_second_nxt;
    end

endmodule

`default_nettype wire

// File: verilog/iot_ctrl_pkg.sv
`default_nettype none

package iot_ctrl_pkg;

    // host function codes, 1 and 2 have no engine
    typedef enum logic [2:0] {
        FN_ENCRYPT  = 3'd1,
        FN_DECRYPT  = 3'd2,
        FN_CRC      = 3'd3,
        FN_TOP2MAX  = 3'd4,
        FN_LAST2MIN = 3'd5
    } fn_sel_t;

    // incoming word vs one candidate, settled by first unequal byte
    typedef enum logic [1:0] {REL_EQUAL, REL_BIGGER, REL_SMALLER} relation_t;

    // output slots of the result sequencer
    typedef enum logic [1:0] {OUT_IDLE, OUT_FIRST, OUT_SECOND} out_state_t;

endpackage

`default_nettype wire

// File: verilog/iot_data_pkg.sv
`default_nettype none

`include "iot_defines.svh"

package iot_data_pkg;

    // raw input byte
    typedef logic [`IOT_BYTE_W-1:0] iot_byte_t;

    // assembled word, also the output width
    typedef logic [`IOT_WORD_W-1:0] iot_word_t;

    typedef logic [`IOT_CRC_W-1:0] crc_t;

    // counters, wrap naturally at their limits
    typedef logic [$clog2(`IOT_WORD_BYTES)-1:0] byte_idx_t;
    typedef logic [$clog2(`IOT_ROUND_WORDS)-1:0] word_cnt_t;

endpackage

`default_nettype wire

// File: verilog/iot_defines.svh
`ifndef IOT_DEFINES_SVH
`define IOT_DEFINES_SVH

// one input byte per accepted strobe
`define IOT_BYTE_W 8

// word geometry, first byte lands in the top byte
`define IOT_WORD_BYTES 16
`define IOT_WORD_W 128

// crc-3, generator x^3+x+1, only the low terms are kept
`define IOT_CRC_W 3
`define IOT_CRC_POLY 3'b011

// words per ranking round
`define IOT_ROUND_WORDS 8

`endif

// File: verilog/iot_filter_top.sv
`timescale 1ns/1ps
`default_nettype none

module iot_filter_top
    import iot_data_pkg::*;
    import iot_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      in_en,
    input  iot_byte_t iot_in,
    input  fn_sel_t   fn_sel,
    output logic      busy,
    output logic      valid,
    output iot_word_t iot_out
);

    // collector to engines
    logic      byte_strobe, first_byte, word_done;
    iot_byte_t cur_byte;
    iot_word_t word;

    // engines to sequencer
    logic      crc_ready, round_ready;
    crc_t      crc_value;
    iot_word_t rank_first, rank_second;

    //////////////////////////////////////////////////////////////////////
    // input side
    //////////////////////////////////////////////////////////////////////

    byte_collector u_collector (
        .clk         (clk),
        .rst         (rst),
        .in_en       (in_en),
        .busy        (busy),
        .iot_in      (iot_in),
        .byte_strobe (byte_strobe),
        .first_byte  (first_byte),
        .word_done   (word_done),
        .cur_byte    (cur_byte),
        .word        (word)
    );

    // both engines watch fn_sel themselves
    crc3_engine u_crc (
        .clk         (clk),
        .rst         (rst),
        .byte_strobe (byte_strobe),
        .first_byte  (first_byte),
        .word_done   (word_done),
        .cur_byte    (cur_byte),
        .fn_sel      (fn_sel),
        .crc_ready   (crc_ready),
        .crc_value   (crc_value)
    );

    extreme_tracker u_tracker (
        .clk         (clk),
        .rst         (rst),
        .byte_strobe (byte_strobe),
        .first_byte  (first_byte),
        .word_done   (word_done),
        .cur_byte    (cur_byte),
        .word        (word),
        .fn_sel      (fn_sel),
        .round_ready (round_ready),
        .rank_first  (rank_first),
        .rank_second (rank_second)
    );

    //////////////////////////////////////////////////////////////////////
    // output side
    //////////////////////////////////////////////////////////////////////

    result_sequencer u_sequencer (
        .clk         (clk),
        .rst         (rst),
        .word_done   (word_done),
        .crc_ready   (crc_ready),
        .round_ready (round_ready),
        .crc_value   (crc_value),
        .rank_first  (rank_first),
        .rank_second (rank_second),
        .busy        (busy),
        .valid       (valid),
        .iot_out     (iot_out)
    );

endmodule

`default_nettype wire

// File: verilog/result_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

`include "iot_defines.svh"

module result_sequencer
    import iot_data_pkg::*;
    import iot_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      word_done,
    input  logic      crc_ready,
    input  logic      round_ready,
    input  crc_t      crc_value,
    input  iot_word_t rank_first,
    input  iot_word_t rank_second,
    output logic      busy,
    output logic      valid,
    output iot_word_t iot_out
);

    out_state_t state;
    logic       busy_r;

    // word_done covers the first busy cycle, busy_r the rest
    assign busy = word_done | busy_r;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= OUT_IDLE;
            busy_r  <= 1'b0;
            valid   <= 1'b0;
            iot_out <= '0;
        end else begin
            case (state)
                OUT_IDLE: begin
                    // no result in the slot after word_done, release
                    busy_r <= word_done;
                    if (crc_ready) begin
                        busy_r  <= 1'b1;
                        valid   <= 1'b1;
                        iot_out <= {{(`IOT_WORD_W - `IOT_CRC_W){1'b0}}, crc_value};
                        state   <= OUT_SECOND;
                    end else if (round_ready) begin
                        busy_r  <= 1'b1;
                        valid   <= 1'b1;
                        iot_out <= rank_first;
                        state   <= OUT_FIRST;
                    end
                end
                // top rank shown, second one next
                OUT_FIRST: begin
                    iot_out <= rank_second;
                    state   <= OUT_SECOND;
                end
                // final word shown, valid and busy drop together
                OUT_SECOND: begin
                    valid  <= 1'b0;
                    busy_r <= 1'b0;
                    state  <= OUT_IDLE;
                end
                default: begin
                    state <= OUT_IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire
